// File: logic/gameport_pkg.sv
package gameport_pkg;

	// Port modes held in the mode register.
	// Code 3 is illegal and is refused by the register block.
	localparam logic [1:0] mode_two_stick   = 2'd0;
	localparam logic [1:0] mode_four_button = 2'd1;
	localparam logic [1:0] mode_gravis      = 2'd2;

	// Byte offsets of the configuration registers.
	localparam logic [3:0] reg_mode_addr   = 4'h0;
	localparam logic [3:0] reg_tick_addr   = 4'h4;
	localparam logic [3:0] reg_grav_addr   = 4'h8;
	localparam logic [3:0] reg_status_addr = 4'hC;

	// AXI4-Lite response codes.
	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	// Clock cycles minus one per axis decrement.
	localparam logic [8:0] tick_div_reset = 9'd265;

	// Clock cycles minus one per serial half-period.
	// About 20 kHz bit rate from a 90.5 MHz core clock.
	localparam logic [11:0] grav_half_reset = 12'd2262;

	// Axis counter width.
	localparam int axis_width = 9;

	// Counter value after reset, so the axis bits start high.
	localparam logic [axis_width-1:0] axis_reset_value = 9'd197;

	// Load for a centred stick or no direction pressed.
	localparam logic [axis_width-1:0] axis_center = 9'd200;

	// Loads for full deflection of a digital direction.
	localparam logic [axis_width-1:0] axis_min = 9'd8;
	localparam logic [axis_width-1:0] axis_max = 9'd391;

	// Serial bit slots per gamepad frame.
	// Header of one low and five highs, then button groups.
	localparam int frame_len = 24;

endpackage

// File: logic/gameport_regs.sv
`timescale 1ns/1ps

module gameport_regs
	import gameport_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic [3:0]  awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,
	input  logic [3:0]  araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready,
	input  logic [7:0]  status,
	output logic [1:0]  mode,
	output logic [8:0]  tick_div,
	output logic [11:0] grav_half
);

	logic        wr_start;
	logic        wr_take;
	logic        wr_err;
	logic        rd_start;
	logic        rd_take;
	logic        rd_err;
	logic [31:0] rd_word;

	// Accept a new write only when both channels are valid and no response is pending.
	assign wr_start = awvalid && wvalid && !awready && !bvalid;
	// Address and data complete together on the ready pulse.
	assign wr_take  = awready && awvalid && wvalid;

	// One read in flight at a time.
	assign rd_start = arvalid && !arready && !rvalid;
	assign rd_take  = arready && arvalid;

	// Write decode.
	// A mode write only counts as illegal when its low byte is enabled.
	always_comb begin
		wr_err = 1'b0;
		case (awaddr)
			reg_mode_addr: begin
				wr_err = wstrb[0] &&
					!(wdata[1:0] inside {mode_two_stick, mode_four_button, mode_gravis});
			end
			reg_tick_addr, reg_grav_addr: wr_err = 1'b0;
			default: wr_err = 1'b1;
		endcase
	end

	// Read decode.
	// Status is a live view of the port byte.
	always_comb begin
		rd_word = '0;
		rd_err  = 1'b0;
		case (araddr)
			reg_mode_addr:   rd_word[1:0]  = mode;
			reg_tick_addr:   rd_word[8:0]  = tick_div;
			reg_grav_addr:   rd_word[11:0] = grav_half;
			reg_status_addr: rd_word[7:0]  = status;
			default:         rd_err        = 1'b1;
		endcase
	end

	// Handshake state and configuration registers.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			awready   <= 1'b0;
			wready    <= 1'b0;
			bvalid    <= 1'b0;
			arready   <= 1'b0;
			rvalid    <= 1'b0;
			mode      <= mode_two_stick;
			tick_div  <= tick_div_reset;
			grav_half <= grav_half_reset;
		end else begin
			// Single-cycle ready pulses.
			awready <= wr_start;
			wready  <= wr_start;
			arready <= rd_start;

			// Response held until the master takes it.
			if (wr_take) begin
				bvalid <= 1'b1;
			end else if (bready) begin
				bvalid <= 1'b0;
			end

			if (rd_take) begin
				rvalid <= 1'b1;
			end else if (rready) begin
				rvalid <= 1'b0;
			end

			// Refused writes leave every register as it was.
			if (wr_take && !wr_err) begin
				case (awaddr)
					reg_mode_addr: begin
						if (wstrb[0]) mode <= wdata[1:0];
					end
					reg_tick_addr: begin
						if (wstrb[0]) tick_div[7:0] <= wdata[7:0];
						if (wstrb[1]) tick_div[8] <= wdata[8];
					end
					reg_grav_addr: begin
						if (wstrb[0]) grav_half[7:0] <= wdata[7:0];
						if (wstrb[1]) grav_half[11:8] <= wdata[11:8];
					end
					default: ;
				endcase
			end
		end
	end

	// Response payload.
	// Only meaningful while the matching valid is high.
	always_ff @(posedge clk) begin
		if (wr_take) begin
			bresp <= wr_err ? resp_slverr : resp_okay;
		end
		if (rd_take) begin
			rdata <= rd_word;
			rresp <= rd_err ? resp_slverr : resp_okay;
		end
	end

	// A pending write response must not vanish or change before bready.
	a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
		bvalid && !bready |=> bvalid && $stable(bresp));

	// Same for the read response and its data.
	a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

	// The encoder has no meaning for code 3.
	a_mode_legal: assert property (@(posedge clk) disable iff (!rst_n)
		mode != 2'd3);

endmodule

// File: logic/axis_oneshot.sv
`timescale 1ns/1ps

module axis_oneshot
	import gameport_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        port_write,
	input  logic [8:0]  tick_div,
	input  logic [13:0] dig_1,
	input  logic [13:0] dig_2,
	input  logic [15:0] ana_1,
	input  logic [15:0] ana_2,
	output logic [3:0]  axis_active
);

	// Counters in port bit order: j1x, j1y, j2x, j2y.
	logic [axis_width-1:0] axis_cnt [4];
	logic [axis_width-1:0] axis_load [4];
	logic [7:0]            ana_byte [4];
	logic [3:0]            dir_neg;
	logic [3:0]            dir_pos;
	logic [8:0]            tick_cnt;
	logic                  tick;

	// Load value for one axis.
	// Analog input scales by 1.5 around the centre, digital falls back to the end stops.
	function automatic logic [axis_width-1:0] load_value(
		input logic [7:0] a,
		input logic       neg,
		input logic       pos
	);
		logic [axis_width-1:0] a_ext;
		logic [axis_width-1:0] value;
		a_ext = {a[7], a};
		if (a != 8'd0) begin
			value = a_ext + {a_ext[axis_width-1], a_ext[axis_width-1:1]} + axis_center;
		end else if (neg) begin
			value = axis_min;
		end else if (pos) begin
			value = axis_max;
		end else begin
			value = axis_center;
		end
		return value;
	endfunction

	// X is the low byte, y the high byte.
	assign ana_byte[0] = ana_1[7:0];
	assign ana_byte[1] = ana_1[15:8];
	assign ana_byte[2] = ana_2[7:0];
	assign ana_byte[3] = ana_2[15:8];

	// Left or up shortens the pulse.
	assign dir_neg = {dig_2[3], dig_2[1], dig_1[3], dig_1[1]};
	// Right or down lengthens it.
	assign dir_pos = {dig_2[2], dig_2[0], dig_1[2], dig_1[0]};

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			axis_load[i] = load_value(ana_byte[i], dir_neg[i], dir_pos[i]);
		end
	end

	// Greater-or-equal keeps the divider sane if tick_div shrinks mid-count.
	assign tick = tick_cnt >= tick_div;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tick_cnt <= '0;
			for (int i = 0; i < 4; i++) begin
				axis_cnt[i] <= axis_reset_value;
			end
		end else if (port_write) begin
			// Write restarts the one-shots and the shared divider.
			tick_cnt <= 9'd1;
			for (int i = 0; i < 4; i++) begin
				axis_cnt[i] <= axis_load[i];
			end
		end else if (tick) begin
			tick_cnt <= '0;
			for (int i = 0; i < 4; i++) begin
				if (axis_cnt[i] != '0) begin
					axis_cnt[i] <= axis_cnt[i] - 1'b1;
				end
			end
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	// Axis bit stays high until its counter runs out.
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			axis_active[i] = axis_cnt[i] != '0;
		end
	end

	// An expired counter holds at zero until the next port write.
	for (genvar g = 0; g < 4; g++) begin : g_no_wrap
		a_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
			(axis_cnt[g] == '0) && !port_write |=> axis_cnt[g] == '0);
	end

endmodule

// File: logic/button_encoder.sv
`timescale 1ns/1ps

module button_encoder
	import gameport_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic [1:0]  mode,
	input  logic [11:0] grav_half,
	input  logic [13:0] dig_1,
	input  logic [13:0] dig_2,
	output logic [3:0]  buttons_n
);

	logic [11:0] half_cnt;
	logic        half_done;
	logic        grav_clk;
	logic        grav_step;
	logic [4:0]  slot;
	logic [1:0]  grav_out;

	// Serial bit for one player in one frame slot.
	// Pressed buttons go out as 1.
	function automatic logic slot_bit(input logic [4:0] pos, input logic [13:0] dig);
		logic b;
		case (pos)
			5'd1, 5'd2, 5'd3, 5'd4, 5'd5: b = 1'b1;
			5'd7:  b = dig[9];
			5'd8:  b = dig[8];
			5'd9:  b = dig[12];
			5'd10: b = dig[7];
			5'd12: b = dig[13];
			5'd13: b = dig[5];
			5'd14: b = dig[4];
			5'd15: b = dig[6];
			5'd17: b = dig[11];
			5'd18: b = dig[10];
			5'd19: b = dig[3];
			5'd20: b = dig[2];
			5'd22: b = dig[0];
			5'd23: b = dig[1];
			// Slot 0 and the group separators.
			default: b = 1'b0;
		endcase
		return b;
	endfunction

	assign half_done = half_cnt >= grav_half;

	// Serial clock and frame sequencer.
	// Held idle outside gravis mode so a frame starts from slot 0.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			half_cnt  <= '0;
			grav_clk  <= 1'b0;
			grav_step <= 1'b0;
			slot      <= '0;
			grav_out  <= '0;
		end else if (mode != mode_gravis) begin
			half_cnt  <= '0;
			grav_clk  <= 1'b0;
			grav_step <= 1'b0;
			slot      <= '0;
			grav_out  <= '0;
		end else begin
			// Flags the cycle the serial clock goes high.
			grav_step <= half_done && !grav_clk;
			if (half_done) begin
				half_cnt <= '0;
				grav_clk <= ~grav_clk;
			end else begin
				half_cnt <= half_cnt + 1'b1;
			end
			// Next bit is launched after the rising edge, read on the falling one.
			if (grav_step) begin
				grav_out <= {slot_bit(slot, dig_2), slot_bit(slot, dig_1)};
				slot     <= (slot == 5'(frame_len - 1)) ? 5'd0 : slot + 1'b1;
			end
		end
	end

	// Button lines, bit 0 is jb1.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			buttons_n <= 4'hF;
		end else begin
			case (mode)
				// Clock on jb1 and jb3, data on jb2 and jb4.
				mode_gravis:      buttons_n <= {grav_out[1], grav_clk, grav_out[0], grav_clk};
				mode_four_button: buttons_n <= ~dig_1[7:4];
				default:          buttons_n <= {~dig_2[5], ~dig_2[4], ~dig_1[5], ~dig_1[4]};
			endcase
		end
	end

	a_slot_range: assert property (@(posedge clk) disable iff (!rst_n)
		slot < 5'(frame_len));

endmodule

// File: logic/gameport_top.sv
`timescale 1ns/1ps

module gameport_top (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [3:0]  awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,
	input  logic [3:0]  araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready,
	input  logic        port_write,
	output logic [7:0]  port_readdata,
	input  logic [13:0] dig_1,
	input  logic [13:0] dig_2,
	input  logic [15:0] ana_1,
	input  logic [15:0] ana_2
);

	logic [1:0]  mode;
	logic [8:0]  tick_div;
	logic [11:0] grav_half;
	logic [3:0]  axis_active;
	logic [3:0]  buttons_n;

	// Port byte as the host sees it at 0x201.
	// Buttons jb4 to jb1 on top, axis bits below.
	assign port_readdata = {buttons_n, axis_active};

	gameport_regs u_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.awaddr    (awaddr),
		.awvalid   (awvalid),
		.awready   (awready),
		.wdata     (wdata),
		.wstrb     (wstrb),
		.wvalid    (wvalid),
		.wready    (wready),
		.bresp     (bresp),
		.bvalid    (bvalid),
		.bready    (bready),
		.araddr    (araddr),
		.arvalid   (arvalid),
		.arready   (arready),
		.rdata     (rdata),
		.rresp     (rresp),
		.rvalid    (rvalid),
		.rready    (rready),
		.status    (port_readdata),
		.mode      (mode),
		.tick_div  (tick_div),
		.grav_half (grav_half)
	);

	axis_oneshot u_axis (
		.clk         (clk),
		.rst_n       (rst_n),
		.port_write  (port_write),
		.tick_div    (tick_div),
		.dig_1       (dig_1),
		.dig_2       (dig_2),
		.ana_1       (ana_1),
		.ana_2       (ana_2),
		.axis_active (axis_active)
	);

	button_encoder u_buttons (
		.clk       (clk),
		.rst_n     (rst_n),
		.mode      (mode),
		.grav_half (grav_half),
		.dig_1     (dig_1),
		.dig_2     (dig_2),
		.buttons_n (buttons_n)
	);

endmodule

// File: testbench/gameport_model.svh
`ifndef GAMEPORT_MODEL_SVH
`define GAMEPORT_MODEL_SVH

// Expected counter load for one axis after a port write.
// Axis order is j1x, j1y, j2x, j2y.
function automatic int axis_load_model(
	input int          axis,
	input logic [15:0] a1,
	input logic [15:0] a2,
	input logic [13:0] d1,
	input logic [13:0] d2
);
	logic [15:0] ana;
	logic [13:0] dig;
	logic [7:0]  a;
	logic        neg;
	logic        pos;
	int          v;
	ana = (axis < 2) ? a1 : a2;
	dig = (axis < 2) ? d1 : d2;
	// X axes use the low byte with left and right, y axes the high byte with up and down.
	a   = axis[0] ? ana[15:8] : ana[7:0];
	neg = axis[0] ? dig[3] : dig[1];
	pos = axis[0] ? dig[2] : dig[0];
	if (a != 8'd0) begin
		// One and a half times the signed byte, around the centre.
		v = int'($signed(a));
		v = (v + (v >>> 1) + int'(axis_center)) & 511;
	end else if (neg) begin
		v = int'(axis_min);
	end else if (pos) begin
		v = int'(axis_max);
	end else begin
		v = int'(axis_center);
	end
	return v;
endfunction

// Upper nibble of the port byte in the direct modes, jb4 down to jb1.
function automatic logic [3:0] buttons_model(
	input logic [1:0]  md,
	input logic [13:0] d1,
	input logic [13:0] d2
);
	logic [3:0] lines;
	if (md == mode_four_button) begin
		// Buttons 1 to 4 of stick 1.
		lines = {~d1[7], ~d1[6], ~d1[5], ~d1[4]};
	end else begin
		// Buttons 1 and 2 of each stick.
		lines = {~d2[5], ~d2[4], ~d1[5], ~d1[4]};
	end
	return lines;
endfunction

// Bit one player sends in one slot of the serial frame.
function automatic logic frame_bit_model(input int slot, input logic [13:0] dig);
	int   map [24];
	logic b;
	// Button index per slot, -1 where the bit is fixed.
	map = '{-1, -1, -1, -1, -1, -1, -1, 9, 8, 12, 7, -1,
		13, 5, 4, 6, -1, 11, 10, 3, 2, -1, 0, 1};
	if (map[slot] >= 0) begin
		b = dig[map[slot]];
	end else begin
		// Header highs in 1 to 5, lows elsewhere.
		b = (slot >= 1) && (slot <= 5);
	end
	return b;
endfunction

`endif

// File: testbench/gameport_tb.sv
`timescale 1ns/1ps

module gameport_tb
	import gameport_pkg::*;
();

	logic        clk;
	logic        rst_n;
	logic [3:0]  awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [3:0]  araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;
	logic        port_write;
	logic [7:0]  port_readdata;
	logic [13:0] dig_1;
	logic [13:0] dig_2;
	logic [15:0] ana_1;
	logic [15:0] ana_2;

	`include "gameport_model.svh"

	gameport_top dut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Print the reason, the fail line, and stop.
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1, "run aborted");
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
		end
	endtask

	// Address and data are offered together, as the slave expects.
	task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output logic [1:0] resp);
		int n;
		@(posedge clk);
		awaddr  <= addr;
		wdata   <= data;
		wstrb   <= strb;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > 50) abort_run("write address was never accepted");
		end while (!awready);
		// Handshake completes on this edge.
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		bready  <= 1'b1;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > 50) abort_run("write response never arrived");
		end while (!bvalid);
		resp = bresp;
		@(posedge clk);
		bready <= 1'b0;
	endtask

	// Rready stays low for stall cycles after rvalid shows up.
	task automatic axi_read(input logic [3:0] addr, input int stall,
		output logic [31:0] data, output logic [1:0] resp);
		int n;
		@(posedge clk);
		araddr  <= addr;
		arvalid <= 1'b1;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > 50) abort_run("read address was never accepted");
		end while (!arready);
		@(posedge clk);
		arvalid <= 1'b0;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > 50) abort_run("read data never arrived");
		end while (!rvalid);
		repeat (stall) @(negedge clk);
		data = rdata;
		resp = rresp;
		@(posedge clk);
		rready <= 1'b1;
		@(posedge clk);
		rready <= 1'b0;
	endtask

	task automatic reg_store(input logic [3:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input logic [1:0] exp_resp);
		logic [1:0] resp;
		axi_write(addr, data, strb, resp);
		check_value($sformatf("bresp at 0x%0h", addr), resp, exp_resp);
	endtask

	task automatic reg_expect(input logic [3:0] addr, input logic [31:0] exp_data,
		input logic [1:0] exp_resp);
		logic [31:0] data;
		logic [1:0]  resp;
		axi_read(addr, $urandom_range(0, 5), data, resp);
		check_value($sformatf("rdata at 0x%0h", addr), data, exp_data);
		check_value($sformatf("rresp at 0x%0h", addr), resp, exp_resp);
	endtask

	// Zero about one time in four, so the digital fallback is hit too.
	function automatic logic [7:0] rand_byte();
		logic [7:0] b;
		if ($urandom_range(0, 3) == 0) begin
			b = 8'h00;
		end else begin
			b = 8'($urandom);
		end
		return b;
	endfunction

	// One port write, then the high time of each axis bit against the model.
	task automatic axis_trial(input logic [15:0] a1, input logic [15:0] a2,
		input logic [13:0] d1, input logic [13:0] d2, input int t);
		int fall [4];
		int n;
		int exp_len;
		int got;
		@(posedge clk);
		ana_1      <= a1;
		ana_2      <= a2;
		dig_1      <= d1;
		dig_2      <= d2;
		port_write <= 1'b1;
		// Counters load on this edge.
		@(posedge clk);
		port_write <= 1'b0;
		fall = '{0, 0, 0, 0};
		n = 0;
		do begin
			@(negedge clk);
			n++;
			for (int i = 0; i < 4; i++) begin
				if (fall[i] == 0 && !port_readdata[i]) fall[i] = n;
			end
			if (n > 400 * (t + 1)) abort_run("an axis bit stayed high too long");
		end while (fall[0] == 0 || fall[1] == 0 || fall[2] == 0 || fall[3] == 0);
		for (int i = 0; i < 4; i++) begin
			exp_len = axis_load_model(i, a1, a2, d1, d2) * (t + 1);
			// One tick of slack either way.
			got = (fall[i] >= exp_len - t - 1 && fall[i] <= exp_len + t + 1) ? exp_len : fall[i];
			check_value($sformatf("axis_active[%0d] high cycles", i), got, exp_len);
		end
	endtask

	initial begin
		logic [1:0]  md;
		logic [8:0]  tv;
		logic [11:0] gv;
		logic [3:0]  bad;
		logic [7:0]  seen;
		logic        p1 [48];
		logic        p2 [48];
		logic        prev;
		int          tick;
		int          count;
		int          n;
		int          hdr;
		void'($urandom(70596));
		rst_n      = 1'b0;
		awaddr     = '0;
		awvalid    = 1'b0;
		wdata      = '0;
		wstrb      = '0;
		wvalid     = 1'b0;
		bready     = 1'b0;
		araddr     = '0;
		arvalid    = 1'b0;
		rready     = 1'b0;
		port_write = 1'b0;
		dig_1      = '0;
		dig_2      = '0;
		ana_1      = '0;
		ana_2      = '0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);

		// Idle lines high, counters still running from reset.
		check_value("port_readdata", port_readdata, 8'hFF);
		reg_expect(reg_mode_addr, 32'(mode_two_stick), resp_okay);
		reg_expect(reg_tick_addr, 32'(tick_div_reset), resp_okay);
		reg_expect(reg_grav_addr, 32'(grav_half_reset), resp_okay);
		repeat (6) begin
			md  = 2'($urandom_range(0, 2));
			tv  = 9'($urandom);
			gv  = 12'($urandom);
			bad = {2'($urandom_range(0, 3)), 2'($urandom_range(1, 3))};
			reg_store(reg_mode_addr, 32'(md), 4'h1, resp_okay);
			reg_store(reg_tick_addr, 32'(tv), 4'h3, resp_okay);
			reg_store(reg_grav_addr, 32'(gv), 4'h3, resp_okay);
			// Refused writes must leave all three registers alone.
			reg_store(reg_mode_addr, 32'd3, 4'h1, resp_slverr);
			reg_store(reg_status_addr, $urandom, 4'hF, resp_slverr);
			reg_store(bad, $urandom, 4'hF, resp_slverr);
			reg_expect(reg_mode_addr, 32'(md), resp_okay);
			reg_expect(reg_tick_addr, 32'(tv), resp_okay);
			reg_expect(reg_grav_addr, 32'(gv), resp_okay);
			reg_expect(bad, 32'h0, resp_slverr);
		end

		// Direct button modes.
		for (int m = 0; m < 2; m++) begin
			md = (m == 0) ? mode_two_stick : mode_four_button;
			reg_store(reg_mode_addr, 32'(md), 4'h1, resp_okay);
			repeat (10) begin
				@(posedge clk);
				dig_1 <= 14'($urandom);
				dig_2 <= 14'($urandom);
				repeat (2) @(negedge clk);
				check_value("port_readdata[7:4]", port_readdata[7:4],
					buttons_model(md, dig_1, dig_2));
			end
		end

		// Axis loads with a short tick.
		tick = $urandom_range(1, 6);
		reg_store(reg_tick_addr, 32'(tick), 4'h3, resp_okay);
		repeat (8) begin
			axis_trial({rand_byte(), rand_byte()}, {rand_byte(), rand_byte()},
				14'($urandom), 14'($urandom), tick);
		end
		// Analog zero, so the directions pick the end stops or the centre.
		axis_trial(16'h0, 16'h0, 14'h000A, 14'h0005, tick);
		axis_trial(16'h0, 16'h0, 14'h0005, 14'h000A, tick);
		axis_trial(16'h0, 16'h0, 14'h0000, 14'h0000, tick);

		// Serial frame, sampled on falling edges of jb1.
		reg_store(reg_grav_addr, 32'($urandom_range(2, 6)), 4'h3, resp_okay);
		@(posedge clk);
		dig_1 <= 14'($urandom);
		dig_2 <= 14'($urandom);
		reg_store(reg_mode_addr, 32'(mode_gravis), 4'h1, resp_okay);
		@(negedge clk);
		prev  = port_readdata[4];
		count = 0;
		n     = 0;
		while (count < 48) begin
			@(negedge clk);
			n++;
			if (n > 5000) abort_run("serial clock on jb1 stopped toggling");
			if (prev && !port_readdata[4]) begin
				p1[count] = port_readdata[5];
				p2[count] = port_readdata[7];
				count++;
			end
			prev = port_readdata[4];
		end
		// Header is one low then five highs, unique in the frame.
		hdr = -1;
		for (int k = 0; k <= 24; k++) begin
			if (hdr < 0 && !p1[k] && p1[k+1] && p1[k+2] && p1[k+3] && p1[k+4] && p1[k+5]) begin
				hdr = k;
			end
		end
		if (hdr < 0) abort_run("no frame header found on jb2");
		for (int j = 0; j < frame_len; j++) begin
			check_value($sformatf("jb2 slot %0d", j), p1[hdr+j], frame_bit_model(j, dig_1));
			check_value($sformatf("jb4 slot %0d", j), p2[hdr+j], frame_bit_model(j, dig_2));
		end

		// Status reads against the predicted port byte.
		// Axis bits ran out in the last trial, so the low nibble is zero.
		reg_store(reg_mode_addr, 32'(mode_two_stick), 4'h1, resp_okay);
		repeat (6) begin
			@(posedge clk);
			dig_1 <= 14'($urandom);
			dig_2 <= 14'($urandom);
			repeat (3) @(negedge clk);
			seen = {buttons_model(mode_two_stick, dig_1, dig_2), 4'h0};
			check_value("port_readdata", port_readdata, seen);
			reg_expect(reg_status_addr, {24'h0, seen}, resp_okay);
		end

		$display("test passed");
		$finish;
	end

endmodule

// File: project.f
+incdir+testbench
logic/gameport_pkg.sv
logic/gameport_regs.sv
logic/axis_oneshot.sv
logic/button_encoder.sv
logic/gameport_top.sv
testbench/gameport_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it; a failing run exits nonzero.
cd "$(dirname "$0")" &&
	verilator --binary --timing --assert -Wno-fatal --top-module gameport_tb \
		-Mdir obj_dir -f project.f &&
	./obj_dir/Vgameport_tb ||
	exit 1
